// File: rr_params.svh
`ifndef RR_PARAMS_SVH
`define RR_PARAMS_SVH

// architectural register count, r0 included
`define RR_NREGS 32

// data path and pc width
`define RR_XLEN 32

// register address width, log2 of RR_NREGS
`define RR_AW 5

// decoded micro-op width
`define RR_UOP_W 8

`endif

// File: rr_wb_pkg.sv
`default_nettype none

`include "rr_params.svh"

package rr_wb_pkg;

    // one write-back port from a later stage
    typedef struct packed {
        logic                we;
        logic [`RR_AW-1:0]   addr;
        logic [`RR_XLEN-1:0] data;
    } rr_wb_t;

    // source operand values for one slot
    typedef struct packed {
        logic [`RR_XLEN-1:0] rj_data;
        logic [`RR_XLEN-1:0] rk_data;
    } rr_opnd_t;

endpackage

`default_nettype wire

// File: rr_pkt_pkg.sv
`default_nettype none

`include "rr_params.svh"

package rr_pkt_pkg;

    import rr_wb_pkg::*;

    // one decoded instruction slot
    typedef struct packed {
        logic                  valid;
        logic [`RR_XLEN-1:0]   pc;
        logic [`RR_UOP_W-1:0]  uop;
        // only meaningful in slot0
        logic                  is_load;
        logic [`RR_AW-1:0]     rj;
        logic [`RR_AW-1:0]     rk;
        logic [`RR_AW-1:0]     rd;
        logic [`RR_XLEN-1:0]   imm;
    } rr_slot_t;

    // dual-issue packet from decode
    typedef struct packed {
        rr_slot_t slot0;
        rr_slot_t slot1;
    } rr_issue_t;

    // packet toward execute, slots plus their operands
    typedef struct packed {
        rr_slot_t slot0;
        rr_slot_t slot1;
        rr_opnd_t opnd0;
        rr_opnd_t opnd1;
    } rr_ex_t;

endpackage

`default_nettype wire

// File: rr_regfile.sv
`default_nettype none

`include "rr_params.svh"

module rr_regfile
    import rr_wb_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              aresetn,
    input  wire rr_wb_t            wb0,
    input  wire rr_wb_t            wb1,
    input  wire rr_wb_t            wb2,
    input  wire logic [`RR_AW-1:0] raddr_j0,
    input  wire logic [`RR_AW-1:0] raddr_k0,
    input  wire logic [`RR_AW-1:0] raddr_j1,
    input  wire logic [`RR_AW-1:0] raddr_k1,
    output rr_opnd_t               opnd0,
    output rr_opnd_t               opnd1
);

    // r0 has no storage
    logic [`RR_XLEN-1:0] regs [1:`RR_NREGS-1];

    // later writes in the block win, so wb2 beats wb1 beats wb0
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 1; i < `RR_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.we && wb0.addr != '0) begin
                regs[wb0.addr] <= wb0.data;
            end
            if (wb1.we && wb1.addr != '0) begin
                regs[wb1.addr] <= wb1.data;
            end
            if (wb2.we && wb2.addr != '0) begin
                regs[wb2.addr] <= wb2.data;
            end
        end
    end

    // write-first read, same priority order as the write side
    function automatic logic [`RR_XLEN-1:0] read_port(input logic [`RR_AW-1:0] addr);
        logic [`RR_XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb2.we && wb2.addr == addr) begin
            val = wb2.data;
        end else if (wb1.we && wb1.addr == addr) begin
            val = wb1.data;
        end else if (wb0.we && wb0.addr == addr) begin
            val = wb0.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        opnd0.rj_data = read_port(raddr_j0);
        opnd0.rk_data = read_port(raddr_k0);
        opnd1.rj_data = read_port(raddr_j1);
        opnd1.rk_data = read_port(raddr_k1);
    end

endmodule

`default_nettype wire

// File: rr_hazard.sv
`default_nettype none

`include "rr_params.svh"

module rr_hazard
    import rr_pkt_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      aresetn,
    input  wire logic      flush,
    input  wire rr_issue_t src_pkt,
    input  wire rr_slot_t  ex_slot0,
    input  wire logic      ex_valid,
    input  wire logic      ex_fire,
    output logic           load_use_stall
);

    logic [`RR_AW-1:0] ex_load_rd;
    logic [`RR_AW-1:0] past_load_rd;
    logic [`RR_AW-1:0] srcs [4];
    logic [3:0]        src_hit;

    // load destination currently sitting in execute, zero if none
    assign ex_load_rd = (ex_valid && ex_slot0.is_load) ? ex_slot0.rd : '0;

    // the load one stage beyond execute, its data is still not back
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            past_load_rd <= '0;
        end else if (flush) begin
            past_load_rd <= '0;
        end else if (ex_fire) begin
            past_load_rd <= ex_load_rd;
        end
    end

    assign srcs[0] = src_pkt.slot0.rj;
    assign srcs[1] = src_pkt.slot0.rk;
    assign srcs[2] = src_pkt.slot1.rj;
    assign srcs[3] = src_pkt.slot1.rk;

    // r0 never waits on a load
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_hit[i] = (srcs[i] != '0)
                       && (srcs[i] == ex_load_rd || srcs[i] == past_load_rd);
        end
    end

    assign load_use_stall = |src_hit;

endmodule

`default_nettype wire

// File: rr_stage_reg.sv
`default_nettype none

module rr_stage_reg
    import rr_wb_pkg::*;
    import rr_pkt_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      aresetn,
    input  wire logic      flush,
    input  wire rr_issue_t in_pkt,
    input  wire logic      in_valid,
    output logic           in_allowin,
    input  wire rr_opnd_t  opnd0,
    input  wire rr_opnd_t  opnd1,
    input  wire logic      load_use_stall,
    input  wire logic      ex_allowin,
    output rr_ex_t         ex_pkt,
    output logic           ex_valid,
    output logic           ex_fire
);

    logic accept;

    // the stage only takes a packet when execute can also move
    assign in_allowin = ex_allowin & ~load_use_stall;
    assign accept     = in_valid & in_allowin;
    assign ex_fire    = ex_valid & ex_allowin;

    // valid tracking
    // flush wins, then a move of execute decides between
    // a new packet and a bubble, otherwise hold
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= accept;
        end
    end

    // payload only moves on acceptance
    // on a bubble it keeps the old contents, ex_valid marks them dead
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pkt.slot0 <= in_pkt.slot0;
            ex_pkt.slot1 <= in_pkt.slot1;
            ex_pkt.opnd0 <= opnd0;
            ex_pkt.opnd1 <= opnd1;
        end
    end

endmodule

`default_nettype wire

// File: rr_stage_top.sv
`default_nettype none

module rr_stage_top
    import rr_wb_pkg::*;
    import rr_pkt_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      aresetn,
    input  wire logic      flush,
    input  wire rr_issue_t in_pkt,
    input  wire logic      in_valid,
    output logic           in_allowin,
    input  wire rr_wb_t    wb0,
    input  wire rr_wb_t    wb1,
    input  wire rr_wb_t    wb2,
    output rr_ex_t         ex_pkt,
    output logic           ex_valid,
    input  wire logic      ex_allowin
);

    rr_opnd_t opnd0;
    rr_opnd_t opnd1;
    logic     load_use_stall;
    logic     ex_fire;

    // operands addressed straight from the decode packet
    rr_regfile u_regfile (
        .clk      (clk),
        .aresetn  (aresetn),
        .wb0      (wb0),
        .wb1      (wb1),
        .wb2      (wb2),
        .raddr_j0 (in_pkt.slot0.rj),
        .raddr_k0 (in_pkt.slot0.rk),
        .raddr_j1 (in_pkt.slot1.rj),
        .raddr_k1 (in_pkt.slot1.rk),
        .opnd0    (opnd0),
        .opnd1    (opnd1)
    );

    // loads can only sit in slot0
    rr_hazard u_hazard (
        .clk            (clk),
        .aresetn        (aresetn),
        .flush          (flush),
        .src_pkt        (in_pkt),
        .ex_slot0       (ex_pkt.slot0),
        .ex_valid       (ex_valid),
        .ex_fire        (ex_fire),
        .load_use_stall (load_use_stall)
    );

    rr_stage_reg u_stage_reg (
        .clk            (clk),
        .aresetn        (aresetn),
        .flush          (flush),
        .in_pkt         (in_pkt),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .opnd0          (opnd0),
        .opnd1          (opnd1),
        .load_use_stall (load_use_stall),
        .ex_allowin     (ex_allowin),
        .ex_pkt         (ex_pkt),
        .ex_valid       (ex_valid),
        .ex_fire        (ex_fire)
    );

endmodule

`default_nettype wire

// File: rr_stage_props.sv
`default_nettype none

module rr_stage_props
    import rr_pkt_pkg::*;
(
    input wire logic   clk,
    input wire logic   aresetn,
    input wire logic   flush,
    input wire logic   load_use_stall,
    input wire logic   ex_allowin,
    input wire logic   ex_valid,
    input wire rr_ex_t ex_pkt
);

    // execute is not taking the packet, so it must not move
    property pkt_held_under_backpressure;
        @(posedge clk) disable iff (!aresetn)
            (ex_valid && !ex_allowin) |=> $stable(ex_pkt);
    endproperty

    property valid_held_under_backpressure;
        @(posedge clk) disable iff (!aresetn)
            (ex_valid && !ex_allowin && !flush) |=> ex_valid;
    endproperty

    // stalled packet is not taken, a bubble moves on instead
    property bubble_on_stall;
        @(posedge clk) disable iff (!aresetn)
            (load_use_stall && ex_allowin) |=> !ex_valid;
    endproperty

    property flush_drops_valid;
        @(posedge clk) disable iff (!aresetn)
            flush |=> !ex_valid;
    endproperty

    a_pkt_hold: assert property (pkt_held_under_backpressure)
        else $error("ex_pkt changed while execute held the stage");

    a_valid_hold: assert property (valid_held_under_backpressure)
        else $error("ex_valid dropped while execute held the stage");

    a_stall: assert property (bubble_on_stall)
        else $error("no bubble after a load-use stall");

    a_flush: assert property (flush_drops_valid)
        else $error("ex_valid still high the cycle after flush");

endmodule

bind rr_stage_reg rr_stage_props u_props (
    .clk            (clk),
    .aresetn        (aresetn),
    .flush          (flush),
    .load_use_stall (load_use_stall),
    .ex_allowin     (ex_allowin),
    .ex_valid       (ex_valid),
    .ex_pkt         (ex_pkt)
);

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic aresetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands on a rising edge, flops still see reset there
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_rr_stage.sv
`default_nettype none

`include "rr_params.svh"

module tb_rr_stage
    import rr_wb_pkg::*;
    import rr_pkt_pkg::*;
();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NCYCLES      = 4000;
    // reset plus stimulus plus a small margin
    localparam int TIMEOUT      = (RESET_CYCLES + NCYCLES + 50) * PERIOD;

    logic      clk;
    logic      aresetn;
    logic      flush;
    rr_issue_t in_pkt;
    logic      in_valid;
    logic      in_allowin;
    rr_wb_t    wb0;
    rr_wb_t    wb1;
    rr_wb_t    wb2;
    rr_ex_t    ex_pkt;
    logic      ex_valid;
    logic      ex_allowin;

    // reference model state
    logic [`RR_XLEN-1:0] mregs [`RR_NREGS];
    rr_ex_t              m_ex_pkt;
    logic                m_ex_valid;
    logic [`RR_AW-1:0]   m_past_ld;

    // what the previous cycle asked for
    rr_ex_t prev_ex_pkt;
    logic   prev_hold;
    logic   prev_flush;

    logic [31:0] rng_state;
    int          n_accept;
    int          n_stall;
    int          n_flush;
    int          n_collide;

    tb_clkgen #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clkgen (
        .clk     (clk),
        .aresetn (aresetn)
    );

    rr_stage_top dut0 (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .in_pkt     (in_pkt),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .wb0        (wb0),
        .wb1        (wb1),
        .wb2        (wb2),
        .ex_pkt     (ex_pkt),
        .ex_valid   (ex_valid),
        .ex_allowin (ex_allowin)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %s at t=%0t: expected %b, actual %b",
                                     name, $time, exp, act));
        end
    endtask

    task automatic compare_pkt(input string name, input rr_ex_t exp, input rr_ex_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %s at t=%0t: expected %h, actual %h",
                                     name, $time, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state;
    endtask

    // r0..r5 only, keeps hazards frequent
    task automatic pick_reg(output logic [`RR_AW-1:0] a);
        logic [31:0] r;
        draw_random(r);
        a = r[`RR_AW-1:0] % 5'd6;
    endtask

    task automatic make_slot(input logic can_load, output rr_slot_t s);
        logic [31:0]       r;
        logic [`RR_AW-1:0] rj;
        logic [`RR_AW-1:0] rk;
        logic [`RR_AW-1:0] rd;
        draw_random(r);
        s.valid   = r[0];
        s.is_load = can_load & r[1];
        s.uop     = r[15:8];
        draw_random(r);
        s.pc = r;
        draw_random(r);
        s.imm = r;
        pick_reg(rj);
        pick_reg(rk);
        pick_reg(rd);
        s.rj = rj;
        s.rk = rk;
        s.rd = rd;
    endtask

    // collide forces every port onto one address
    task automatic make_wb(input logic [`RR_AW-1:0] shared, input logic collide,
                           output rr_wb_t w);
        logic [31:0] r;
        draw_random(r);
        w.we   = r[0] | collide;
        w.addr = collide ? shared : {2'b00, r[7:5]};
        draw_random(r);
        w.data = r;
    endtask

    task automatic drive_inputs();
        logic [31:0]       r;
        rr_slot_t          s0;
        rr_slot_t          s1;
        rr_wb_t            w0;
        rr_wb_t            w1;
        rr_wb_t            w2;
        logic [`RR_AW-1:0] shared;
        logic              collide;
        make_slot(1'b1, s0);
        make_slot(1'b0, s1);
        draw_random(r);
        collide = (r[2:0] == 3'd0);
        shared  = {2'b00, r[6:4]};
        make_wb(shared, collide, w0);
        make_wb(shared, collide, w1);
        make_wb(shared, collide, w2);
        draw_random(r);
        in_pkt.slot0 <= s0;
        in_pkt.slot1 <= s1;
        wb0          <= w0;
        wb1          <= w1;
        wb2          <= w2;
        in_valid     <= r[8] | r[9];
        ex_allowin   <= (r[12:11] != 2'd0);
        flush        <= (r[23:16] < 8'd6);
    endtask

    // write-first read, highest port wins, r0 reads zero
    function automatic logic [`RR_XLEN-1:0] model_read(input logic [`RR_AW-1:0] a);
        logic [`RR_XLEN-1:0] v;
        v = mregs[a];
        if (wb0.we && wb0.addr == a) v = wb0.data;
        if (wb1.we && wb1.addr == a) v = wb1.data;
        if (wb2.we && wb2.addr == a) v = wb2.data;
        if (a == '0) v = '0;
        return v;
    endfunction

    function automatic logic [`RR_AW-1:0] model_ex_load_rd();
        return (m_ex_valid && m_ex_pkt.slot0.is_load) ? m_ex_pkt.slot0.rd : '0;
    endfunction

    function automatic logic src_blocked(input logic [`RR_AW-1:0] src);
        logic [`RR_AW-1:0] ld;
        ld = model_ex_load_rd();
        return (src != '0) && (src == ld || src == m_past_ld);
    endfunction

    function automatic logic model_stall();
        return src_blocked(in_pkt.slot0.rj) || src_blocked(in_pkt.slot0.rk)
            || src_blocked(in_pkt.slot1.rj) || src_blocked(in_pkt.slot1.rk);
    endfunction

    task automatic write_model(input rr_wb_t w);
        if (w.we && w.addr != '0) begin
            mregs[w.addr] = w.data;
        end
    endtask

    task automatic check_outputs();
        logic stall;
        stall = model_stall();
        if (prev_flush) compare_bit("flush_clear", 1'b0, ex_valid);
        if (prev_hold) compare_pkt("backpressure_hold", prev_ex_pkt, ex_pkt);
        compare_bit("ex_valid", m_ex_valid, ex_valid);
        if (m_ex_valid) compare_pkt("operand_read", m_ex_pkt, ex_pkt);
        compare_bit("allowin_rule", ex_allowin && !stall, in_allowin);
        if (stall) n_stall++;
    endtask

    // state after the coming rising edge, inputs are stable until then
    task automatic advance_model();
        logic              stall;
        logic              accept;
        logic              fire;
        logic [`RR_AW-1:0] ld;
        rr_ex_t            nxt;
        stall       = model_stall();
        ld          = model_ex_load_rd();
        accept      = in_valid && ex_allowin && !stall;
        fire        = m_ex_valid && ex_allowin;
        prev_ex_pkt = m_ex_pkt;
        prev_hold   = m_ex_valid && !ex_allowin;
        prev_flush  = flush;
        if (accept) begin
            nxt.slot0         = in_pkt.slot0;
            nxt.slot1         = in_pkt.slot1;
            nxt.opnd0.rj_data = model_read(in_pkt.slot0.rj);
            nxt.opnd0.rk_data = model_read(in_pkt.slot0.rk);
            nxt.opnd1.rj_data = model_read(in_pkt.slot1.rj);
            nxt.opnd1.rk_data = model_read(in_pkt.slot1.rk);
            m_ex_pkt          = nxt;
            n_accept++;
        end
        if (flush) begin
            m_past_ld  = '0;
            m_ex_valid = 1'b0;
            n_flush++;
        end else begin
            if (fire) m_past_ld = ld;
            if (ex_allowin) m_ex_valid = accept;
        end
        if ((wb0.we && wb1.we && wb0.addr == wb1.addr)
                || (wb1.we && wb2.we && wb1.addr == wb2.addr)) begin
            n_collide++;
        end
        // later port overwrites, same order as the priority
        write_model(wb0);
        write_model(wb1);
        write_model(wb2);
    endtask

    initial begin
        #(TIMEOUT);
        report_failure($sformatf("run hung: not finished after %0d time units", TIMEOUT));
    end

    initial begin
        rng_state   = 32'd64;
        n_accept    = 0;
        n_stall     = 0;
        n_flush     = 0;
        n_collide   = 0;
        m_ex_pkt    = '0;
        m_ex_valid  = 1'b0;
        m_past_ld   = '0;
        prev_ex_pkt = '0;
        prev_hold   = 1'b0;
        prev_flush  = 1'b0;
        for (int i = 0; i < `RR_NREGS; i++) begin
            mregs[i] = '0;
        end
        flush      <= 1'b0;
        in_pkt     <= '0;
        in_valid   <= 1'b0;
        ex_allowin <= 1'b0;
        wb0        <= '0;
        wb1        <= '0;
        wb2        <= '0;
        wait (aresetn === 1'b1);
        @(negedge clk);
        advance_model();
        for (int cyc = 0; cyc < NCYCLES; cyc++) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_outputs();
            advance_model();
        end
        if (n_accept == 0 || n_stall == 0 || n_flush == 0 || n_collide == 0) begin
            report_failure("stimulus missed accepts, stalls, flushes or port collisions");
        end
        $display("accepted %0d, stalled %0d, flushed %0d, collisions %0d",
                 n_accept, n_stall, n_flush, n_collide);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
rr_wb_pkg.sv
rr_pkt_pkg.sv
rr_regfile.sv
rr_hazard.sv
rr_stage_reg.sv
rr_stage_top.sv
rr_stage_props.sv
tb_clkgen.sv
tb_rr_stage.sv

// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat verilog.f)) rr_params.svh

obj_dir/Vtb_rr_stage: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rr_stage -f verilog.f -o Vtb_rr_stage

run: obj_dir/Vtb_rr_stage
	./obj_dir/Vtb_rr_stage

clean:
	rm -rf obj_dir

.PHONY: run clean
